// ==== rtl/rv_pkg.sv ====
// rv32i execute slice definitions

package rv_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------

    localparam int XLEN     = 32;
    localparam int XLEN_LOG = 5;    // shifter stages
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] xdata_t;   // operand or result
    typedef logic [4:0]      reg_idx_t;
    typedef logic [31:0]     instr_t;

    // ----------------------------------------------------------------------
    // instruction encoding constants
    // ----------------------------------------------------------------------

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub / sra

    // ----------------------------------------------------------------------
    // operation codes
    // ----------------------------------------------------------------------

    // low bits follow funct3, bit 3 is funct7[5]
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        OR   = 4'b0110,
        AND  = 4'b0111,
        SUB  = 4'b1000,
        SRA  = 4'b1101,
        MOV  = 4'b1111     // right operand passthrough, lui
    } alu_op_e;

    // branch funct3
    typedef enum logic [2:0] {
        EQ  = 3'b000,
        NE  = 3'b001,
        LT  = 3'b100,
        GE  = 3'b101,
        LTU = 3'b110,
        GEU = 3'b111
    } cmp_op_e;

    // ----------------------------------------------------------------------
    // bundles
    // ----------------------------------------------------------------------

    typedef struct packed {
        alu_op_e  alu_op;
        cmp_op_e  cmp_op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        xdata_t   imm;
        logic     use_imm;     // right operand from imm
        logic     zero_left;   // left operand forced to zero
        logic     wr_en;
        logic     is_branch;
    } dec_t;

    typedef struct packed {
        reg_idx_t rd;
        xdata_t   data;
    } wb_t;

endpackage

// ==== rtl/rv_decode.sv ====
// rv32i instruction decoder

`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
    input  instr_t instr_i,
    output dec_t   dec_o,
    output logic   legal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xdata_t     imm_i;
    xdata_t     imm_u;
    xdata_t     imm_b;
    logic       legal;
    logic       wr;
    logic       br;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // ----------------------------------------------------------------------
    // immediates, all sign extended from bit 31
    // ----------------------------------------------------------------------

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    // funct3 to alu op, alt picks sub or sra
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    // ----------------------------------------------------------------------
    // main decode
    // ----------------------------------------------------------------------

    always_comb begin
        dec_o.alu_op    = ADD;
        dec_o.cmp_op    = EQ;
        dec_o.rs1       = instr_i[19:15];
        dec_o.rs2       = instr_i[24:20];
        dec_o.rd        = instr_i[11:7];
        dec_o.imm       = imm_i;
        dec_o.use_imm   = 1'b0;
        dec_o.zero_left = 1'b0;
        legal           = 1'b0;
        wr              = 1'b0;
        br              = 1'b0;

        case (opcode)
            OPC_OP: begin
                wr = 1'b1;
                if (funct7 == F7_BASE) begin
                    legal        = 1'b1;
                    dec_o.alu_op = alu_from_funct3(funct3, 1'b0);
                end else if (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)) begin
                    legal        = 1'b1;
                    dec_o.alu_op = alu_from_funct3(funct3, 1'b1);
                end
            end
            OPC_OP_IMM: begin
                wr            = 1'b1;
                dec_o.use_imm = 1'b1;
                // funct7 only matters for the shift encodings
                case (funct3)
                    3'b001:  legal = (funct7 == F7_BASE);
                    3'b101:  legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    default: legal = 1'b1;
                endcase
                dec_o.alu_op = alu_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
            end
            OPC_LUI: begin
                legal           = 1'b1;
                wr              = 1'b1;
                dec_o.alu_op    = MOV;
                dec_o.imm       = imm_u;
                dec_o.use_imm   = 1'b1;
                dec_o.zero_left = 1'b1;
            end
            OPC_BRANCH: begin
                legal        = (funct3[2:1] != 2'b01);   // 010 and 011 unused
                br           = 1'b1;
                dec_o.cmp_op = cmp_op_e'(funct3);
                dec_o.imm    = imm_b;
            end
            default: begin
            end
        endcase

        dec_o.wr_en     = wr & legal;
        dec_o.is_branch = br & legal;
        legal_o         = legal;
    end

endmodule

// ==== rtl/rv_regfile.sv ====
// integer register file

`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    output xdata_t   rs1_data_o,
    output xdata_t   rs2_data_o,
    input  logic     wr_en_i,
    input  wb_t      wb_i
);

    xdata_t regs [1:NUM_REGS-1];   // x0 has no storage

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // one read port with write-through bypass
    function automatic xdata_t read_port(input reg_idx_t idx);
        xdata_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wr_en_i && idx == wb_i.rd) begin
            val = wb_i.data;   // pending write wins
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

// ==== rtl/rv_alu.sv ====
// registered alu and branch comparator

`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    clk_en_i,
    input  xdata_t  op_left_i,
    input  xdata_t  op_right_i,
    input  alu_op_e op_code_i,
    output xdata_t  op_result_o,
    input  xdata_t  cmp_left_i,
    input  xdata_t  cmp_right_i,
    input  cmp_op_e cmp_code_i,
    output logic    cmp_result_o
);

    xdata_t shl_stage [0:XLEN_LOG];
    xdata_t shr_stage [0:XLEN_LOG];
    logic   shr_fill;
    xdata_t result_mux;
    logic   cmp_eq;
    logic   cmp_lt;
    logic   cmp_ltu;
    logic   cmp_mux;

    // ----------------------------------------------------------------------
    // logarithmic shifter
    // ----------------------------------------------------------------------

    // arithmetic shift fills with the sign bit
    assign shr_fill = (op_code_i == SRA) & op_left_i[XLEN-1];

    assign shl_stage[0] = op_left_i;
    assign shr_stage[0] = op_left_i;

    // stage s moves by 2**s when bit s of the amount is set
    for (genvar s = 0; s < XLEN_LOG; s++) begin : g_shift
        assign shl_stage[s+1] = op_right_i[s] ?
            {shl_stage[s][XLEN-1-2**s:0], {(2**s){1'b0}}} : shl_stage[s];
        assign shr_stage[s+1] = op_right_i[s] ?
            {{(2**s){shr_fill}}, shr_stage[s][XLEN-1:2**s]} : shr_stage[s];
    end

    // ----------------------------------------------------------------------
    // result mux
    // ----------------------------------------------------------------------

    always_comb begin
        case (op_code_i)
            ADD:     result_mux = op_left_i + op_right_i;
            SUB:     result_mux = op_left_i - op_right_i;
            SLL:     result_mux = shl_stage[XLEN_LOG];
            SLT:     result_mux = {{(XLEN-1){1'b0}},
                                   $signed(op_left_i) < $signed(op_right_i)};
            SLTU:    result_mux = {{(XLEN-1){1'b0}}, op_left_i < op_right_i};
            XOR:     result_mux = op_left_i ^ op_right_i;
            SRL,
            SRA:     result_mux = shr_stage[XLEN_LOG];
            OR:      result_mux = op_left_i | op_right_i;
            AND:     result_mux = op_left_i & op_right_i;
            MOV:     result_mux = op_right_i;
            default: result_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            op_result_o <= '0;
        end else if (clk_en_i) begin
            op_result_o <= result_mux;
        end
    end

    // ----------------------------------------------------------------------
    // branch comparator
    // ----------------------------------------------------------------------

    assign cmp_eq  = (cmp_left_i == cmp_right_i);
    assign cmp_lt  = ($signed(cmp_left_i) < $signed(cmp_right_i));
    assign cmp_ltu = (cmp_left_i < cmp_right_i);

    always_comb begin
        case (cmp_code_i)
            EQ:      cmp_mux = cmp_eq;
            NE:      cmp_mux = ~cmp_eq;
            LT:      cmp_mux = cmp_lt;
            GE:      cmp_mux = ~cmp_lt;
            LTU:     cmp_mux = cmp_ltu;
            GEU:     cmp_mux = ~cmp_ltu;
            default: cmp_mux = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cmp_result_o <= 1'b0;
        end else if (clk_en_i) begin
            cmp_result_o <= cmp_mux;
        end
    end

endmodule

// ==== rtl/rv_exec_top.sv ====
// rv32i execute slice top

`timescale 1ns/1ps

module rv_exec_top import rv_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   clk_en_i,
    input  instr_t instr_i,
    input  logic   instr_valid_i,
    output logic   wb_valid_o,
    output wb_t    wb_o,
    output logic   br_valid_o,
    output logic   br_taken_o
);

    dec_t     dec;
    logic     legal;
    xdata_t   rs1_data;
    xdata_t   rs2_data;
    xdata_t   op_left;
    xdata_t   op_right;
    xdata_t   alu_result;
    logic     cmp_result;
    logic     wb_valid_q;
    logic     br_valid_q;
    reg_idx_t wb_rd_q;
    wb_t      wb;

    rv_decode i_rv_decode (
        .instr_i (instr_i),
        .dec_o   (dec),
        .legal_o (legal)
    );

    rv_regfile i_rv_regfile (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_i      (dec.rs1),
        .rs2_i      (dec.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_en_i    (wb_valid_q & clk_en_i),   // write holds during a stall
        .wb_i       (wb)
    );

    // operand select
    assign op_left  = dec.zero_left ? '0 : rs1_data;
    assign op_right = dec.use_imm ? dec.imm : rs2_data;

    rv_alu i_rv_alu (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .clk_en_i     (clk_en_i),
        .op_left_i    (op_left),
        .op_right_i   (op_right),
        .op_code_i    (dec.alu_op),
        .op_result_o  (alu_result),
        .cmp_left_i   (rs1_data),
        .cmp_right_i  (rs2_data),
        .cmp_code_i   (dec.cmp_op),
        .cmp_result_o (cmp_result)
    );

    // strobes and rd, aligned with the alu register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_q <= 1'b0;
            br_valid_q <= 1'b0;
            wb_rd_q    <= '0;
        end else if (clk_en_i) begin
            wb_valid_q <= instr_valid_i & dec.wr_en & legal;
            br_valid_q <= instr_valid_i & dec.is_branch;
            wb_rd_q    <= dec.rd;
        end
    end

    assign wb.rd   = wb_rd_q;
    assign wb.data = alu_result;

    assign wb_valid_o = wb_valid_q;
    assign wb_o       = wb;
    assign br_valid_o = br_valid_q;
    assign br_taken_o = br_valid_q & cmp_result;   // low outside a branch

endmodule

// ==== test/rv_exec_chk.sv ====
// execute slice assertions

`timescale 1ns/1ps

module rv_exec_chk import rv_pkg::*; (
    input logic     clk_i,
    input logic     rst_i,
    input logic     clk_en_i,
    input logic     wb_valid_i,
    input wb_t      wb_i,
    input logic     br_valid_i,
    input logic     br_taken_i,
    input reg_idx_t rs1_i,
    input reg_idx_t rs2_i,
    input xdata_t   rs1_data_i,
    input xdata_t   rs2_data_i
);

    int fail_count = 0;

    // strobes cleared by a reset edge
    reset_strobes: assert property (@(posedge clk_i) rst_i |=> (!wb_valid_i && !br_valid_i))
        else begin
            fail_count++;
            $error("valid strobe high after a reset edge");
        end

    // outputs frozen across a disabled edge
    stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        !clk_en_i |=> $stable({wb_valid_i, wb_i, br_valid_i, br_taken_i}))
        else begin
            fail_count++;
            $error("outputs changed during a stall");
        end

    // a pending write to x0 must not leak into x0 reads
    x0_reads: assert property (@(posedge clk_i) disable iff (rst_i)
        (wb_valid_i && wb_i.rd == '0) |->
        ((rs1_i != '0 || rs1_data_i == '0) && (rs2_i != '0 || rs2_data_i == '0)))
        else begin
            fail_count++;
            $error("x0 read returned a nonzero value");
        end

endmodule

bind rv_exec_top rv_exec_chk i_rv_exec_chk (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .clk_en_i   (clk_en_i),
    .wb_valid_i (wb_valid_o),
    .wb_i       (wb_o),
    .br_valid_i (br_valid_o),
    .br_taken_i (br_taken_o),
    .rs1_i      (dec.rs1),
    .rs2_i      (dec.rs2),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data)
);

// ==== test/tb_rv_exec.sv ====
// rv32i execute slice testbench

`timescale 1ns/1ps

module tb_rv_exec import rv_pkg::*; ();

    localparam int WAIT_LIMIT = 20;    // cycles allowed for a writeback strobe

    // one table row holding stimulus then expected outputs
    typedef struct packed {
        instr_t   instr;
        logic     valid;
        logic     en;
        logic     wb;
        reg_idx_t rd;
        xdata_t   data;
        logic     br;
        logic     taken;
    } row_t;

    logic   clk;
    logic   rst;
    logic   clk_en;
    instr_t instr;
    logic   instr_valid;
    logic   wb_valid;
    wb_t    wb;
    logic   br_valid;
    logic   br_taken;

    row_t   rows [$];
    xdata_t model [0:NUM_REGS-1];      // architectural register model
    int     seed;
    int     errors;
    int     checks;
    int     assert_fails;
    logic   timed_out;

    rv_exec_top i_rv_exec_top (
        .clk_i         (clk),
        .rst_i         (rst),
        .clk_en_i      (clk_en),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .wb_valid_o    (wb_valid),
        .wb_o          (wb),
        .br_valid_o    (br_valid),
        .br_taken_o    (br_taken)
    );

    always #50 clk = ~clk;

    // ----------------------------------------------------------------------
    // instruction encoders
    // ----------------------------------------------------------------------

    function automatic instr_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                      input reg_idx_t rd, input reg_idx_t rs1,
                                      input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t i_type(input logic [2:0] f3, input reg_idx_t rd,
                                      input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic instr_t u_type(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic instr_t b_type(input logic [2:0] f3, input reg_idx_t rs1,
                                      input reg_idx_t rs2);
        return {7'b0, rs2, rs1, f3, 5'b0, OPC_BRANCH};   // zero offset
    endfunction

    // reference result of an r-type op
    function automatic xdata_t alu_model(input logic [2:0] f3, input logic alt,
                                         input xdata_t a, input xdata_t b);
        xdata_t r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = {31'b0, $signed(a) < $signed(b)};
            3'b011:  r = {31'b0, a < b};
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // table construction
    // ----------------------------------------------------------------------

    task automatic wb_row(input instr_t ins, input reg_idx_t rd, input xdata_t data);
        rows.push_back('{ins, 1'b1, 1'b1, 1'b1, rd, data, 1'b0, 1'b0});
    endtask

    task automatic br_row(input instr_t ins, input logic taken);
        rows.push_back('{ins, 1'b1, 1'b1, 1'b0, 5'd0, 32'h0, 1'b1, taken});
    endtask

    // row with no strobe expected, also used for stalls
    task automatic quiet_row(input instr_t ins, input logic valid, input logic en);
        rows.push_back('{ins, valid, en, 1'b0, 5'd0, 32'h0, 1'b0, 1'b0});
    endtask

    task automatic build_table();
        // immediates and lui then add and sub with wrap
        wb_row(i_type(3'b000, 5'd1, 5'd0, 12'h005), 5'd1, 32'h0000_0005);
        wb_row(i_type(3'b000, 5'd2, 5'd0, 12'hfff), 5'd2, 32'hffff_ffff);
        wb_row(u_type(5'd3, 20'h80000), 5'd3, 32'h8000_0000);
        wb_row(r_type(F7_BASE, 3'b000, 5'd4, 5'd1, 5'd2), 5'd4, 32'h0000_0004);
        wb_row(r_type(F7_ALT, 3'b000, 5'd5, 5'd3, 5'd1), 5'd5, 32'h7fff_fffb);
        wb_row(r_type(F7_BASE, 3'b000, 5'd6, 5'd3, 5'd3), 5'd6, 32'h0000_0000);
        wb_row(u_type(5'd7, 20'h12345), 5'd7, 32'h1234_5000);
        wb_row(i_type(3'b000, 5'd7, 5'd7, 12'h678), 5'd7, 32'h1234_5678);
        // shifts by 0, 1, 31 and by register amounts above 31
        wb_row(i_type(3'b001, 5'd8, 5'd7, 12'h000), 5'd8, 32'h1234_5678);
        wb_row(i_type(3'b001, 5'd8, 5'd7, 12'h001), 5'd8, 32'h2468_acf0);
        wb_row(i_type(3'b001, 5'd8, 5'd1, 12'h01f), 5'd8, 32'h8000_0000);
        wb_row(i_type(3'b101, 5'd9, 5'd3, 12'h001), 5'd9, 32'h4000_0000);
        wb_row(i_type(3'b101, 5'd9, 5'd3, 12'h401), 5'd9, 32'hc000_0000);
        wb_row(i_type(3'b101, 5'd9, 5'd3, 12'h41f), 5'd9, 32'hffff_ffff);
        wb_row(i_type(3'b101, 5'd9, 5'd3, 12'h01f), 5'd9, 32'h0000_0001);
        wb_row(i_type(3'b101, 5'd9, 5'd2, 12'h000), 5'd9, 32'hffff_ffff);
        wb_row(i_type(3'b101, 5'd9, 5'd3, 12'h400), 5'd9, 32'h8000_0000);
        wb_row(i_type(3'b000, 5'd10, 5'd0, 12'h021), 5'd10, 32'h0000_0021);
        wb_row(r_type(F7_BASE, 3'b001, 5'd11, 5'd1, 5'd10), 5'd11, 32'h0000_000a);
        wb_row(r_type(F7_ALT, 3'b101, 5'd11, 5'd3, 5'd10), 5'd11, 32'hc000_0000);
        wb_row(r_type(F7_BASE, 3'b101, 5'd11, 5'd7, 5'd10), 5'd11, 32'h091a_2b3c);
        wb_row(r_type(F7_ALT, 3'b101, 5'd11, 5'd3, 5'd2), 5'd11, 32'hffff_ffff);
        // logic ops and set-less-than where signed and unsigned orders differ
        wb_row(r_type(F7_BASE, 3'b111, 5'd12, 5'd7, 5'd10), 5'd12, 32'h0000_0020);
        wb_row(r_type(F7_BASE, 3'b110, 5'd12, 5'd7, 5'd3), 5'd12, 32'h9234_5678);
        wb_row(r_type(F7_BASE, 3'b100, 5'd12, 5'd7, 5'd2), 5'd12, 32'hedcb_a987);
        wb_row(i_type(3'b100, 5'd12, 5'd7, 12'h0ff), 5'd12, 32'h1234_5687);
        wb_row(i_type(3'b111, 5'd12, 5'd2, 12'h7f0), 5'd12, 32'h0000_07f0);
        wb_row(i_type(3'b110, 5'd12, 5'd0, 12'h800), 5'd12, 32'hffff_f800);
        wb_row(r_type(F7_BASE, 3'b010, 5'd13, 5'd3, 5'd1), 5'd13, 32'h0000_0001);
        wb_row(r_type(F7_BASE, 3'b011, 5'd13, 5'd3, 5'd1), 5'd13, 32'h0000_0000);
        wb_row(r_type(F7_BASE, 3'b010, 5'd13, 5'd1, 5'd2), 5'd13, 32'h0000_0000);
        wb_row(r_type(F7_BASE, 3'b011, 5'd13, 5'd1, 5'd2), 5'd13, 32'h0000_0001);
        wb_row(i_type(3'b010, 5'd13, 5'd2, 12'h000), 5'd13, 32'h0000_0001);
        wb_row(i_type(3'b011, 5'd13, 5'd1, 12'hfff), 5'd13, 32'h0000_0001);
        // branches on x1 = 5, x2 = -1 and x3 = most negative
        br_row(b_type(3'b000, 5'd1, 5'd1), 1'b1);
        br_row(b_type(3'b000, 5'd3, 5'd1), 1'b0);
        br_row(b_type(3'b001, 5'd1, 5'd1), 1'b0);
        br_row(b_type(3'b001, 5'd1, 5'd2), 1'b1);
        br_row(b_type(3'b100, 5'd3, 5'd1), 1'b1);
        br_row(b_type(3'b100, 5'd1, 5'd2), 1'b0);
        br_row(b_type(3'b100, 5'd1, 5'd1), 1'b0);
        br_row(b_type(3'b101, 5'd3, 5'd1), 1'b0);
        br_row(b_type(3'b101, 5'd1, 5'd1), 1'b1);
        br_row(b_type(3'b101, 5'd1, 5'd2), 1'b1);
        br_row(b_type(3'b110, 5'd1, 5'd2), 1'b1);
        br_row(b_type(3'b110, 5'd3, 5'd1), 1'b0);
        br_row(b_type(3'b110, 5'd1, 5'd1), 1'b0);
        br_row(b_type(3'b111, 5'd3, 5'd1), 1'b1);
        br_row(b_type(3'b111, 5'd1, 5'd2), 1'b0);
        br_row(b_type(3'b111, 5'd1, 5'd1), 1'b1);
        // back-to-back dependencies then a write to x0
        wb_row(i_type(3'b000, 5'd14, 5'd0, 12'h064), 5'd14, 32'h0000_0064);
        wb_row(i_type(3'b000, 5'd14, 5'd14, 12'h001), 5'd14, 32'h0000_0065);
        wb_row(r_type(F7_BASE, 3'b000, 5'd15, 5'd14, 5'd14), 5'd15, 32'h0000_00ca);
        wb_row(i_type(3'b000, 5'd0, 5'd1, 12'h007), 5'd0, 32'h0000_000c);
        wb_row(r_type(F7_BASE, 3'b000, 5'd16, 5'd0, 5'd1), 5'd16, 32'h0000_0005);
        // stall with a pending write then resume
        wb_row(i_type(3'b000, 5'd17, 5'd0, 12'h055), 5'd17, 32'h0000_0055);
        quiet_row(i_type(3'b000, 5'd17, 5'd17, 12'h001), 1'b1, 1'b0);
        quiet_row(i_type(3'b000, 5'd17, 5'd17, 12'h001), 1'b1, 1'b0);
        quiet_row(i_type(3'b000, 5'd17, 5'd17, 12'h001), 1'b1, 1'b0);
        wb_row(i_type(3'b000, 5'd18, 5'd17, 12'h001), 5'd18, 32'h0000_0056);
        // illegal encodings give no strobe
        quiet_row(32'h0000_007f, 1'b1, 1'b1);
        quiet_row(r_type(7'b0000001, 3'b000, 5'd20, 5'd1, 5'd1), 1'b1, 1'b1);
        quiet_row(b_type(3'b010, 5'd1, 5'd1), 1'b1, 1'b1);
        wb_row(r_type(F7_BASE, 3'b000, 5'd19, 5'd18, 5'd1), 5'd19, 32'h0000_005b);
    endtask

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------

    task automatic check_value(input string name, input xdata_t exp, input xdata_t got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("CHECK FAILED %s exp %h got %h", name, exp, got);
        end
    endtask

    task automatic check_outputs(input row_t exp);
        check_value("wb_valid_o", exp.wb, wb_valid);
        check_value("br_valid_o", exp.br, br_valid);
        check_value("br_taken_o", exp.taken, br_taken);
        if (exp.wb) begin
            check_value("wb_o.rd", exp.rd, wb.rd);
            check_value("wb_o.data", exp.data, wb.data);
        end
    endtask

    task automatic compare_regs();
        for (int r = 1; r < NUM_REGS; r++) begin
            check_value($sformatf("x%0d", r), model[r], i_rv_exec_top.i_rv_regfile.regs[r]);
        end
    endtask

    task automatic wait_for_wb();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_valid && cycles < WAIT_LIMIT);
        if (!wb_valid) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout, no writeback strobe seen within %0d cycles", WAIT_LIMIT);
        end
    endtask

    // ----------------------------------------------------------------------
    // phases
    // ----------------------------------------------------------------------

    // row i is driven while the outputs of row i-1 are checked
    task automatic run_table();
        row_t exp;
        row_t last;
        int   n;
        last = '0;
        n    = rows.size();
        for (int i = 0; i <= n; i++) begin
            @(posedge clk);
            if (i < n) begin
                instr       <= rows[i].instr;
                instr_valid <= rows[i].valid;
                clk_en      <= rows[i].en;
            end else begin
                instr       <= '0;
                instr_valid <= 1'b0;
                clk_en      <= 1'b1;
            end
            @(negedge clk);
            if (i > 0) begin
                exp = rows[i-1].en ? rows[i-1] : last;   // stalled rows hold
                check_outputs(exp);
                if (rows[i-1].en) begin
                    last = rows[i-1];
                    if (exp.wb && exp.rd != '0) begin
                        model[exp.rd] = exp.data;
                    end
                end
            end
        end
    endtask

    task automatic run_random(input int count);
        int       v;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic [2:0] f3;
        logic     alt;
        xdata_t   exp;
        for (int k = 0; k < count && !timed_out; k++) begin
            v   = $random(seed);
            rs1 = v[19:15];
            rs2 = v[24:20];
            rd  = v[11:7];
            f3  = v[14:12];
            alt = v[30] && (f3 == 3'b000 || f3 == 3'b101);
            exp = alu_model(f3, alt, model[rs1], model[rs2]);
            @(posedge clk);
            instr       <= r_type(alt ? F7_ALT : F7_BASE, f3, rd, rs1, rs2);
            instr_valid <= 1'b1;
            clk_en      <= 1'b1;
            @(posedge clk);
            instr_valid <= 1'b0;   // single issue
            wait_for_wb();
            if (!timed_out) begin
                check_value("wb_o.rd", rd, wb.rd);
                check_value("wb_o.data", exp, wb.data);
                check_value("br_valid_o", 1'b0, br_valid);
                if (rd != '0) begin
                    model[rd] = exp;
                end
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        clk_en      = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        seed        = 77;
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model[r] = '0;
        end
        build_table();

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        run_table();
        repeat (2) @(posedge clk);   // let the last write land
        @(negedge clk);
        compare_regs();

        run_random(40);
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (!timed_out) begin
            compare_regs();
        end

        assert_fails = i_rv_exec_top.i_rv_exec_chk.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/rv_pkg.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_exec_top.sv
test/rv_exec_chk.sv
test/tb_rv_exec.sv

// ==== Bender.yml ====
package:
  name: rv_exec

sources:
  - rtl/rv_pkg.sv
  - rtl/rv_decode.sv
  - rtl/rv_regfile.sv
  - rtl/rv_alu.sv
  - rtl/rv_exec_top.sv
  - target: test
    files:
      - test/rv_exec_chk.sv
      - test/tb_rv_exec.sv
